/* Bender.yml */
package:
  name: rs_station

export_include_dirs:
  - src

sources:
  - files:
      - src/rs_pkg.sv
      - src/rot_pri_sel.sv
      - src/rs_entry.sv
      - src/rs_ctrl.sv
      - src/rs_top.sv
  - target: test
    files:
      - test/rs_tb.sv

/* src/rot_pri_sel.sv */
/* rotational priority selector
   grants the first request found at or after head and wraps past the top */
module rot_pri_sel #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req,
    input  logic [$clog2(WIDTH)-1:0] head,   // highest priority position
    output logic [WIDTH-1:0]         gnt,    // one-hot or zero
    output logic                     any
);

    ////////////////////
    // search from head
    ////////////////////

    // walk WIDTH positions starting at head
    always_comb begin
        int   idx;
        logic found;
        gnt   = '0;
        found = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = (int'(head) + k) % WIDTH;   // wraps past the top
            if (!found && req[idx]) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;              // later positions lose
            end
        end
    end

    assign any = |req;   // some grant goes out

    ////////////////////
    // checks
    ////////////////////

    // exactly one grant whenever any request is up
    a_gnt_onehot: assert #0 ($onehot0(gnt) && (any == (|gnt)))
        else $error("rot_pri_sel grant not one-hot or out of step with requests");

endmodule

/* src/rs_ctrl.sv */
/* reservation station control
   allocates free entries, picks the oldest ready op by rob age and registers the issue */
`include "rs_defs.svh"

module rs_ctrl (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             dispatch_valid,
    input  logic [`TAG_W-1:0]                rob_head,     // oldest rob tag
    input  logic [`RS_LEN-1:0]               busy,
    input  logic [`RS_LEN-1:0]               ready,
    input  logic [`RS_LEN-1:0][`TAG_W-1:0]   dest_tags,
    input  rs_pkg::issue_pkt_t [`RS_LEN-1:0] entry_pkts,
    output logic [`RS_LEN-1:0]               entry_wr,     // one-hot
    output logic [`RS_LEN-1:0]               entry_clr,    // one-hot
    output logic                             issue_valid,
    output rs_pkg::issue_pkt_t               issue,
    output logic                             rs_full
);
    import rs_pkg::*;

    logic [`RS_LEN-1:0]  free_oh;   // lowest free slot
    logic [`ROB_LEN-1:0] cand_d;    // ready ops by rob position
    logic [`ROB_LEN-1:0] cand_q;
    logic [`ROB_LEN-1:0] gnt_pos;   // winning rob position
    logic                gnt_any;
    issue_pkt_t          issue_d;

    ////////////////////
    // allocation
    ////////////////////
    always_comb begin
        free_oh = '0;
        for (int i = 0; i < `RS_LEN; i++) begin
            if (!busy[i] && (free_oh == '0))
                free_oh[i] = 1'b1;
        end
    end

    assign entry_wr = dispatch_valid ? free_oh : '0;   // packet dropped when nothing free
    assign rs_full  = &busy;

    ////////////////////
    // issue select
    ////////////////////

    // tags are unique so each rob position has at most one entry
    always_comb begin
        cand_d = '0;
        for (int i = 0; i < `RS_LEN; i++) begin
            if (ready[i] && !entry_clr[i])      // leaving this edge
                cand_d[dest_tags[i]] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            cand_q <= '0;
        else
            cand_q <= cand_d;
    end

    rot_pri_sel #(.WIDTH(`ROB_LEN)) u_sel (
        .req  (cand_q),
        .head (rob_head),
        .gnt  (gnt_pos),
        .any  (gnt_any)
    );

    // winning position back to its entry
    always_comb begin
        entry_clr = '0;
        issue_d   = '0;
        for (int i = 0; i < `RS_LEN; i++) begin
            if (gnt_any && busy[i] && gnt_pos[dest_tags[i]]) begin
                entry_clr[i] = 1'b1;
                issue_d      = entry_pkts[i];
            end
        end
    end

    ////////////////////
    // issue register
    ////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            issue_valid <= 1'b0;
        else
            issue_valid <= gnt_any;   // one cycle strobe
    end

    always_ff @(posedge clock) begin
        if (gnt_any)
            issue <= issue_d;
    end

    // upstream holds off while full
    a_no_disp_full: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_valid |-> !rs_full)
        else $error("dispatch while station full, packet dropped");

    // a position latched last cycle still names exactly one entry
    a_gnt_maps: assert property (@(posedge clock) disable iff (!rst_n)
        gnt_any |-> $onehot(entry_clr))
        else $error("issue grant does not map to a single entry");

endmodule

/* src/rs_defs.svh */
/* sizes shared by the reservation station RTL and its testbench
   include wherever entry count, tag width or operand width is needed */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

////////////////////
// station geometry
////////////////////
`define RS_LEN   8      // entries in the station
`define ROB_LEN  8      // rob tags kept equal to RS_LEN
`define TAG_W    3      // bits of a rob tag

////////////////////
// datapath
////////////////////
`define XLEN     32     // operand width

`endif

/* src/rs_entry.sv */
/* one reservation station slot
   holds a dispatched op, snoops the cdb for missing operands and offers it once ready */
`include "rs_defs.svh"

module rs_entry (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  wr,        // load dispatch packet
    input  logic                  clr,       // free after issue
    input  rs_pkg::dispatch_pkt_t dispatch,
    input  logic                  cdb_valid,
    input  rs_pkg::cdb_pkt_t      cdb,
    output logic                  busy,
    output logic                  ready,
    output logic [`TAG_W-1:0]     dest_tag,
    output rs_pkg::issue_pkt_t    pkt
);
    import rs_pkg::*;

    // control state
    logic busy_q;
    logic opa_rdy_q;
    logic opb_rdy_q;

    // payload
    inst_t             inst_q;
    logic [`TAG_W-1:0] dest_q;
    logic [`TAG_W-1:0] opa_tag_q;
    logic [`TAG_W-1:0] opb_tag_q;
    logic [`XLEN-1:0]  opa_val_q;
    logic [`XLEN-1:0]  opb_val_q;

    src_t opa_cur;
    src_t opb_cur;
    src_t opa_nxt;
    src_t opb_nxt;
    src_t imm_src;   // opb built from imm12
    logic upd;       // operand regs follow next state

    // pick up a broadcast value for a still waiting operand
    function automatic src_t wake(input src_t s, input logic v, input cdb_pkt_t c);
        src_t r;
        r = s;
        if (!s.ready && v && (s.tag == c.tag)) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

    assign opa_cur = '{ready: opa_rdy_q, tag: opa_tag_q, value: opa_val_q};
    assign opb_cur = '{ready: opb_rdy_q, tag: opb_tag_q, value: opb_val_q};
    assign imm_src = '{ready: 1'b1, tag: '0,
                       value: {{(`XLEN-12){dispatch.inst.i.imm12[11]}}, dispatch.inst.i.imm12}};
    assign upd     = wr | busy_q;

    ////////////////////
    // operand next state
    ////////////////////
    always_comb begin
        if (wr) begin
            opa_nxt = wake(dispatch.src1, cdb_valid, cdb);   // same-cycle forward
            opb_nxt = dispatch.opb_is_imm ? imm_src : wake(dispatch.src2, cdb_valid, cdb);
        end else begin
            opa_nxt = wake(opa_cur, cdb_valid, cdb);
            opb_nxt = wake(opb_cur, cdb_valid, cdb);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            opa_rdy_q <= 1'b0;
            opb_rdy_q <= 1'b0;
        end else if (clr) begin
            busy_q    <= 1'b0;   // slot free next cycle
            opa_rdy_q <= 1'b0;
            opb_rdy_q <= 1'b0;
        end else if (upd) begin
            busy_q    <= 1'b1;
            opa_rdy_q <= opa_nxt.ready;
            opb_rdy_q <= opb_nxt.ready;
        end
    end

    always_ff @(posedge clock) begin
        if (wr) begin
            inst_q <= dispatch.inst;
            dest_q <= dispatch.dest_tag;
        end
        if (upd) begin
            opa_tag_q <= opa_nxt.tag;
            opa_val_q <= opa_nxt.value;
            opb_tag_q <= opb_nxt.tag;
            opb_val_q <= opb_nxt.value;
        end
    end

    // outputs
    assign busy         = busy_q;
    assign ready        = busy_q & opa_rdy_q & opb_rdy_q;
    assign dest_tag     = dest_q;
    assign pkt.opcode   = inst_q.r.opcode;
    assign pkt.funct3   = inst_q.r.funct3;
    assign pkt.funct7   = inst_q.r.funct7;
    assign pkt.dest_tag = dest_q;
    assign pkt.opa      = opa_val_q;
    assign pkt.opb      = opb_val_q;

    // allocator must only pick a free slot
    a_wr_free: assert property (@(posedge clock) disable iff (!rst_n) wr |-> !busy_q)
        else $error("rs_entry written while busy");

endmodule

/* src/rs_pkg.sv */
/* types shared across the reservation station
   instruction views plus the dispatch, cdb and issue packets */
`include "rs_defs.svh"

package rs_pkg;

    ////////////////////
    // instruction word
    ////////////////////

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // immediate layout where imm12 replaces funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_t;

    ////////////////////
    // packets
    ////////////////////

    typedef struct packed {
        logic              ready;   // value already valid
        logic [`TAG_W-1:0] tag;     // producer tag while waiting
        logic [`XLEN-1:0]  value;
    } src_t;

    typedef struct packed {
        inst_t             inst;
        logic [`TAG_W-1:0] dest_tag;
        src_t              src1;
        src_t              src2;
        logic              opb_is_imm;  // i-type takes imm12 for opb
    } dispatch_pkt_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } cdb_pkt_t;

    typedef struct packed {
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic [6:0]        funct7;
        logic [`TAG_W-1:0] dest_tag;
        logic [`XLEN-1:0]  opa;
        logic [`XLEN-1:0]  opb;
    } issue_pkt_t;

endpackage

/* src/rs_top.sv */
/* reservation station top level
   eight entries sharing dispatch and cdb inputs under one controller */
`include "rs_defs.svh"

module rs_top (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  dispatch_valid,   // single-cycle strobe
    input  rs_pkg::dispatch_pkt_t dispatch,
    input  logic                  cdb_valid,
    input  rs_pkg::cdb_pkt_t      cdb,
    input  logic [`TAG_W-1:0]     rob_head,
    output logic                  issue_valid,
    output rs_pkg::issue_pkt_t    issue,
    output logic                  rs_full
);
    import rs_pkg::*;

    // per-entry wiring
    logic [`RS_LEN-1:0]             entry_wr;
    logic [`RS_LEN-1:0]             entry_clr;
    logic [`RS_LEN-1:0]             busy;
    logic [`RS_LEN-1:0]             ready;
    logic [`RS_LEN-1:0][`TAG_W-1:0] dest_tags;
    issue_pkt_t [`RS_LEN-1:0]       entry_pkts;

    ////////////////////
    // entries
    ////////////////////
    for (genvar g = 0; g < `RS_LEN; g++) begin : g_entry
        rs_entry u_entry (
            .clock     (clock),
            .rst_n     (rst_n),
            .wr        (entry_wr[g]),
            .clr       (entry_clr[g]),
            .dispatch  (dispatch),     // same packet to all
            .cdb_valid (cdb_valid),
            .cdb       (cdb),
            .busy      (busy[g]),
            .ready     (ready[g]),
            .dest_tag  (dest_tags[g]),
            .pkt       (entry_pkts[g])
        );
    end

    ////////////////////
    // control
    ////////////////////
    rs_ctrl u_ctrl (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .rob_head       (rob_head),
        .busy           (busy),
        .ready          (ready),
        .dest_tags      (dest_tags),
        .entry_pkts     (entry_pkts),
        .entry_wr       (entry_wr),
        .entry_clr      (entry_clr),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rs_full        (rs_full)
    );

endmodule

/* test/rs_input.txt */
# T name | H rob_head | D inst dest s1_rdy s1_tag s1_val s2_rdy s2_tag s2_val opb_imm
# C tag value | I cycles | E opcode dest opa opb | F rs_full ; inst, values, opcode in hex
T basic
F 0
D 002081b3 1 1 0 00000011 1 0 00000022 0
E 33 1 00000011 00000022
I 4
T itype
D ffd08293 2 1 0 00000100 0 7 00000000 1
D 7ff08293 3 1 0 00000200 0 7 00000000 1
E 13 2 00000100 fffffffd
E 13 3 00000200 000007ff
I 4
T wakeup
D 40208233 4 0 5 deadbeef 1 0 00000007 0
I 10
C 5 00000064
E 33 4 00000064 00000007
C 7 0000abcd
D 002081b3 6 0 7 deadbeef 0 7 deadbeef 0
E 33 6 0000abcd 0000abcd
I 4
T age
H 5
D 002081b3 3 0 0 00000000 1 0 00000033 0
D 002081b3 7 0 0 00000000 1 0 00000077 0
D 002081b3 1 0 0 00000000 1 0 00000011 0
D 002081b3 6 0 0 00000000 1 0 00000066 0
I 3
C 0 00000500
E 33 6 00000500 00000066
E 33 7 00000500 00000077
E 33 1 00000500 00000011
E 33 3 00000500 00000033
I 4
T full
H 2
D 002081b3 0 0 4 00000000 1 0 00000100 0
D 002081b3 1 0 4 00000000 1 0 00000101 0
D 002081b3 2 0 4 00000000 1 0 00000102 0
D 002081b3 3 0 4 00000000 1 0 00000103 0
D 002081b3 4 0 4 00000000 1 0 00000104 0
D 002081b3 5 0 4 00000000 1 0 00000105 0
D 002081b3 6 0 4 00000000 1 0 00000106 0
F 0
D 002081b3 7 0 4 00000000 1 0 00000107 0
F 1
C 4 00004444
E 33 2 00004444 00000102
E 33 3 00004444 00000103
E 33 4 00004444 00000104
E 33 5 00004444 00000105
E 33 6 00004444 00000106
E 33 7 00004444 00000107
E 33 0 00004444 00000100
E 33 1 00004444 00000101
I 2
F 0

/* test/rs_tb.sv */
/* testbench for the reservation station top level
   replays test/rs_input.txt record by record and checks each issue against it */
`include "rs_defs.svh"

module rs_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rs_pkg::*;

    localparam int WAIT_LIMIT = 100;   // cycles allowed per expected issue

    logic              clock;
    logic              rst_n;
    logic              dispatch_valid;
    dispatch_pkt_t     dispatch;
    logic              cdb_valid;
    cdb_pkt_t          cdb;
    logic [`TAG_W-1:0] rob_head;
    logic              issue_valid;
    issue_pkt_t        issue;
    logic              rs_full;

    issue_pkt_t      seen_q[$];     // issues in arrival order
    logic [31:0]     inst_by_tag [`ROB_LEN];   // last word dispatched per dest tag
    logic [8*24-1:0] test_name;
    logic            disp_pend;     // dispatch strobe up this cycle
    logic            cdb_pend;      // cdb strobe up this cycle

    rs_top DUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .rob_head       (rob_head),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rs_full        (rs_full)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    // issue is registered so the pre-edge value belongs to the last cycle
    always @(posedge clock) begin
        if (rst_n && issue_valid)
            seen_q.push_back(issue);
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic die(input string msg);
        $display("%0s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // one falling edge with strobes dropped
    task automatic step();
        @(negedge clock);
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
        disp_pend      = 1'b0;
        cdb_pend       = 1'b0;
    endtask

    task automatic flush();
        if (disp_pend || cdb_pend)
            step();   // let the pending strobes see one edge
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else die($sformatf("ERR %0s: %0s expected %h got %h", test_name, what, exp, act));
    endtask

    task automatic expect_issue(input logic [31:0] opc, input int dest,
                                input logic [31:0] opa, input logic [31:0] opb);
        int         waited;
        issue_pkt_t got;
        waited = 0;
        while (seen_q.size() == 0 && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        assert (seen_q.size() != 0)
            else die($sformatf("test %0s: no issue came within %0d cycles",
                               test_name, WAIT_LIMIT));
        got = seen_q.pop_front();
        check_val("opcode", opc, got.opcode);
        check_val("funct3", inst_by_tag[dest][14:12], got.funct3);   // r view fields
        check_val("funct7", inst_by_tag[dest][31:25], got.funct7);
        check_val("dest_tag", dest, got.dest_tag);
        check_val("opa", opa, got.opa);
        check_val("opb", opb, got.opb);
    endtask

    ////////////////////
    // record player
    ////////////////////
    initial begin
        int               fd;
        int               n;
        int               f_dest;
        int               f_r1;
        int               f_t1;
        int               f_r2;
        int               f_t2;
        int               f_imm;
        logic [31:0]      f_inst;
        logic [31:0]      f_val1;
        logic [31:0]      f_val2;
        logic [8*8-1:0]   kind;
        logic [8*128-1:0] line_buf;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb_valid      = 1'b0;
        cdb            = '0;
        rob_head       = '0;
        disp_pend      = 1'b0;
        cdb_pend       = 1'b0;
        test_name      = "reset";
        repeat (5) @(negedge clock);
        rst_n = 1'b1;
        check_val("issue_valid", 0, issue_valid);   // quiet out of reset
        check_val("rs_full", 0, rs_full);

        fd = $fopen("test/rs_input.txt", "r");
        assert (fd != 0) else die("could not open test/rs_input.txt for reading");
        while (!$feof(fd)) begin
            kind = '0;
            n = $fscanf(fd, "%s", kind);
            if (n != 1)
                break;   // trailing blank lines
            case (kind)
                "#": n = $fgets(line_buf, fd);
                "T": begin
                    flush();
                    test_name = '0;
                    n = $fscanf(fd, "%s", test_name);
                    assert (seen_q.size() == 0)
                        else die("an issue arrived that no expected record asked for");
                end
                "H": begin
                    flush();
                    n = $fscanf(fd, "%d", f_dest);
                    rob_head = f_dest[`TAG_W-1:0];
                end
                "D": begin
                    n = $fscanf(fd, "%h %d %d %d %h %d %d %h %d", f_inst, f_dest,
                                f_r1, f_t1, f_val1, f_r2, f_t2, f_val2, f_imm);
                    assert (n == 9) else die("malformed dispatch record in input file");
                    if (disp_pend)
                        step();   // back to back dispatches
                    inst_by_tag[f_dest[`TAG_W-1:0]] = f_inst;
                    dispatch.inst       = f_inst;
                    dispatch.dest_tag   = f_dest[`TAG_W-1:0];
                    dispatch.src1.ready = f_r1[0];
                    dispatch.src1.tag   = f_t1[`TAG_W-1:0];
                    dispatch.src1.value = f_val1;
                    dispatch.src2.ready = f_r2[0];
                    dispatch.src2.tag   = f_t2[`TAG_W-1:0];
                    dispatch.src2.value = f_val2;
                    dispatch.opb_is_imm = f_imm[0];
                    dispatch_valid      = 1'b1;
                    disp_pend           = 1'b1;
                end
                "C": begin
                    n = $fscanf(fd, "%d %h", f_t1, f_val1);
                    if (cdb_pend)
                        step();
                    cdb.tag   = f_t1[`TAG_W-1:0];
                    cdb.value = f_val1;
                    cdb_valid = 1'b1;
                    cdb_pend  = 1'b1;
                end
                "I": begin
                    n = $fscanf(fd, "%d", f_dest);
                    flush();
                    repeat (f_dest) step();
                end
                "E": begin
                    n = $fscanf(fd, "%h %d %h %h", f_inst, f_dest, f_val1, f_val2);
                    assert (n == 4) else die("malformed expected issue record in input file");
                    flush();
                    expect_issue(f_inst, f_dest, f_val1, f_val2);
                end
                "F": begin
                    n = $fscanf(fd, "%d", f_dest);
                    flush();
                    check_val("rs_full", f_dest, rs_full);
                end
                default: die("unknown record kind in input file");
            endcase
        end
        $fclose(fd);
        flush();
        repeat (8) step();   // drain window for stray issues
        if (seen_q.size() != 0)
            die("an issue arrived after the last expected record");
        else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+src
src/rs_pkg.sv
src/rot_pri_sel.sv
src/rs_entry.sv
src/rs_ctrl.sv
src/rs_top.sv
test/rs_tb.sv
